//--- verilog/rvc_config.svh
// shared widths for the compressed expander
// fixed register indices and field patterns
`ifndef RVC_CONFIG_SVH
`define RVC_CONFIG_SVH

// full and compressed instruction widths
`define RVC_ILEN 32
`define RVC_CLEN 16

// architectural registers used implicitly by rvc forms
`define RVC_REG_ZERO 5'd0
`define RVC_REG_RA 5'd1
`define RVC_REG_SP 5'd2

// rd'/rs1'/rs2' prefix, maps x8..x15
`define RVC_CREG_BASE 2'b01

// low bits of a 32-bit encoding
`define RVC_QUAD_FULL 2'b11

`endif

//--- verilog/rvc_pkg.sv
// field typedefs and major opcode enum for the expander
// instruction packing functions for the r, i, s, b, u and j formats
`default_nettype none

`include "rvc_config.svh"

package rvc_pkg;

	typedef logic [`RVC_ILEN-1:0] instr_t;
	typedef logic [`RVC_CLEN-1:0] cinstr_t;
	typedef logic [4:0] reg_idx_t;
	typedef logic [2:0] funct3_t;
	typedef logic [6:0] funct7_t;
	typedef logic [11:0] imm12_t;
	typedef logic [19:0] imm20_t;

	// instr[6:2], only the ones an rvc form expands into
	typedef enum logic [4:0] {
		OPC_LOAD = 5'b00000,
		OPC_OP_IMM = 5'b00100,
		OPC_OP_IMM32 = 5'b00110,
		OPC_STORE = 5'b01000,
		OPC_OP = 5'b01100,
		OPC_LUI = 5'b01101,
		OPC_OP32 = 5'b01110,
		OPC_BRANCH = 5'b11000,
		OPC_JALR = 5'b11001,
		OPC_JAL = 5'b11011,
		OPC_SYSTEM = 5'b11100
	} opcode_e;

	// register-register
	function automatic instr_t pack_r(opcode_e opc, reg_idx_t rd, funct3_t f3,
			reg_idx_t rs1, reg_idx_t rs2, funct7_t f7);
		return {f7, rs2, rs1, f3, rd, opc, `RVC_QUAD_FULL};
	endfunction

	// immediate, loads, jalr, system
	function automatic instr_t pack_i(opcode_e opc, reg_idx_t rd, funct3_t f3,
			reg_idx_t rs1, imm12_t imm);
		return {imm, rs1, f3, rd, opc, `RVC_QUAD_FULL};
	endfunction

	// stores, offset split around rs2/rs1
	function automatic instr_t pack_s(opcode_e opc, funct3_t f3, reg_idx_t rs1,
			reg_idx_t rs2, imm12_t imm);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], opc, `RVC_QUAD_FULL};
	endfunction

	// branches
	// imm holds offset[12:1], bit 0 is always zero
	function automatic instr_t pack_b(opcode_e opc, funct3_t f3, reg_idx_t rs1,
			reg_idx_t rs2, imm12_t imm);
		return {imm[11], imm[9:4], rs2, rs1, f3, imm[3:0], imm[10], opc, `RVC_QUAD_FULL};
	endfunction

	// upper immediate, imm is instr[31:12]
	function automatic instr_t pack_u(opcode_e opc, reg_idx_t rd, imm20_t imm);
		return {imm, rd, opc, `RVC_QUAD_FULL};
	endfunction

	// jal
	// imm holds offset[20:1]
	function automatic instr_t pack_j(opcode_e opc, reg_idx_t rd, imm20_t imm);
		return {imm[19], imm[9:0], imm[10], imm[18:11], rd, opc, `RVC_QUAD_FULL};
	endfunction

endpackage

`default_nettype wire

//--- verilog/rvc_quadrant0_dec.sv
// quadrant 0 expansion: c.addi4spn, c.lw, c.ld, c.sw, c.sd
// float and zcb encodings flagged illegal
`default_nettype none

`include "rvc_config.svh"

module rvc_quadrant0_dec import rvc_pkg::*; (
	input cinstr_t cinstr_i,
	output instr_t instr_o,
	output logic illegal_o
);

	reg_idx_t rd_p;
	reg_idx_t rs1_p;
	imm12_t w_off;
	imm12_t d_off;

	// rd' and rs2' share bits 4:2
	assign rd_p = {`RVC_CREG_BASE, cinstr_i[4:2]};
	assign rs1_p = {`RVC_CREG_BASE, cinstr_i[9:7]};

	// word offset, scaled by 4
	assign w_off = {5'b0, cinstr_i[5], cinstr_i[12:10], cinstr_i[6], 2'b00};
	// double offset, scaled by 8
	assign d_off = {4'b0, cinstr_i[6:5], cinstr_i[12:10], 3'b000};

	always_comb begin
		instr_o = '0;
		illegal_o = 1'b0;
		case (cinstr_i[15:13])
			3'b000: begin
				// addi4spn, nzuimm scaled by 4
				instr_o = pack_i(OPC_OP_IMM, rd_p, 3'b000, `RVC_REG_SP,
					{2'b00, cinstr_i[10:7], cinstr_i[12:11], cinstr_i[5], cinstr_i[6], 2'b00});
				// zero immediate is reserved, covers all-zero word
				illegal_o = ~|cinstr_i[12:5];
			end
			// lw
			3'b010: instr_o = pack_i(OPC_LOAD, rd_p, 3'b010, rs1_p, w_off);
			// ld
			3'b011: instr_o = pack_i(OPC_LOAD, rd_p, 3'b011, rs1_p, d_off);
			// sw
			3'b110: instr_o = pack_s(OPC_STORE, 3'b010, rs1_p, rd_p, w_off);
			// sd
			3'b111: instr_o = pack_s(OPC_STORE, 3'b011, rs1_p, rd_p, d_off);
			// fld, fsd, zcb group
			default: illegal_o = 1'b1;
		endcase
	end

endmodule

`default_nettype wire

//--- verilog/rvc_quadrant1_dec.sv
// quadrant 1 expansion: immediates, lui, shifts, andi, register alu ops
// plus c.j and the two compare-with-zero branches
`default_nettype none

`include "rvc_config.svh"

module rvc_quadrant1_dec import rvc_pkg::*; (
	input cinstr_t cinstr_i,
	output instr_t instr_o,
	output logic illegal_o
);

	reg_idx_t rd;
	reg_idx_t rd_p;
	reg_idx_t rs2_p;
	imm12_t imm6_sx;
	imm12_t sp16_imm;
	imm12_t br_imm;
	imm20_t lui_imm;
	imm20_t j_imm;
	funct3_t alu_f3;

	assign rd = cinstr_i[11:7];
	assign rd_p = {`RVC_CREG_BASE, cinstr_i[9:7]};
	assign rs2_p = {`RVC_CREG_BASE, cinstr_i[4:2]};

	// six-bit immediate, sign from bit 12
	assign imm6_sx = {{6{cinstr_i[12]}}, cinstr_i[12], cinstr_i[6:2]};
	assign lui_imm = {{14{cinstr_i[12]}}, cinstr_i[12], cinstr_i[6:2]};

	// addi16sp nzimm[9:4]
	assign sp16_imm = {{2{cinstr_i[12]}}, cinstr_i[12], cinstr_i[4:3], cinstr_i[5],
		cinstr_i[2], cinstr_i[6], 4'b0000};

	// offset[11:1] scrambled over bits 12:2
	assign j_imm = {{9{cinstr_i[12]}}, cinstr_i[12], cinstr_i[8], cinstr_i[10:9],
		cinstr_i[6], cinstr_i[7], cinstr_i[2], cinstr_i[11], cinstr_i[5:3]};

	// offset[8:1] for beqz/bnez
	assign br_imm = {{4{cinstr_i[12]}}, cinstr_i[12], cinstr_i[6:5], cinstr_i[2],
		cinstr_i[11:10], cinstr_i[4:3]};

	// sub 000, xor 100, or 110, and 111
	assign alu_f3 = {|cinstr_i[6:5], cinstr_i[6], &cinstr_i[6:5]};

	always_comb begin
		instr_o = '0;
		illegal_o = 1'b0;
		case (cinstr_i[15:13])
			// addi
			3'b000: instr_o = pack_i(OPC_OP_IMM, rd, 3'b000, rd, imm6_sx);
			// addiw, rv64 only so no c.jal here
			3'b001: instr_o = pack_i(OPC_OP_IMM32, rd, 3'b000, rd, imm6_sx);
			// li, adds to x0
			3'b010: instr_o = pack_i(OPC_OP_IMM, rd, 3'b000, `RVC_REG_ZERO, imm6_sx);
			3'b011: begin
				// rd of sp selects addi16sp over lui
				if (rd == `RVC_REG_SP)
					instr_o = pack_i(OPC_OP_IMM, rd, 3'b000, rd, sp16_imm);
				else
					instr_o = pack_u(OPC_LUI, rd, lui_imm);
			end
			3'b100: begin
				casez (cinstr_i[11:10])
					// srli, srai; bit 10 sets the arithmetic flag
					2'b0?: instr_o = pack_i(OPC_OP_IMM, rd_p, 3'b101, rd_p,
						{1'b0, cinstr_i[10], 4'b0000, cinstr_i[12], cinstr_i[6:2]});
					// andi
					2'b10: instr_o = pack_i(OPC_OP_IMM, rd_p, 3'b111, rd_p, imm6_sx);
					default: begin
						casez ({cinstr_i[12], cinstr_i[6:5]})
							// sub only has funct7 bit 5 set
							3'b0??: instr_o = pack_r(OPC_OP, rd_p, alu_f3, rd_p, rs2_p,
								{1'b0, ~|cinstr_i[6:5], 5'b00000});
							// subw, addw
							3'b10?: instr_o = pack_r(OPC_OP32, rd_p, 3'b000, rd_p, rs2_p,
								{1'b0, ~cinstr_i[5], 5'b00000});
							// reserved, zcb mul/zext/sext/not
							default: illegal_o = 1'b1;
						endcase
					end
				endcase
			end
			// j, jal with no link
			3'b101: instr_o = pack_j(OPC_JAL, `RVC_REG_ZERO, j_imm);
			// beqz, bnez; bit 13 gives funct3 bit 0
			default: instr_o = pack_b(OPC_BRANCH, {2'b00, cinstr_i[13]}, rd_p,
				`RVC_REG_ZERO, br_imm);
		endcase
	end

endmodule

`default_nettype wire

//--- verilog/rvc_quadrant2_dec.sv
// quadrant 2 expansion: slli, sp-relative loads and stores
// jr, jalr, mv, add and ebreak from the funct3 100 group
`default_nettype none

`include "rvc_config.svh"

module rvc_quadrant2_dec import rvc_pkg::*; (
	input cinstr_t cinstr_i,
	output instr_t instr_o,
	output logic illegal_o
);

	reg_idx_t rd;
	reg_idx_t rs2;
	reg_idx_t link_rd;
	reg_idx_t add_rs1;

	assign rd = cinstr_i[11:7];
	assign rs2 = cinstr_i[6:2];

	// bit 12 picks jalr over jr, add over mv
	assign link_rd = cinstr_i[12] ? `RVC_REG_RA : `RVC_REG_ZERO;
	assign add_rs1 = cinstr_i[12] ? rd : `RVC_REG_ZERO;

	always_comb begin
		instr_o = '0;
		illegal_o = 1'b0;
		case (cinstr_i[15:13])
			// slli, shamt[5] from bit 12
			3'b000: instr_o = pack_i(OPC_OP_IMM, rd, 3'b001, rd,
				{6'b000000, cinstr_i[12], cinstr_i[6:2]});
			// lwsp, offset scaled by 4
			3'b010: instr_o = pack_i(OPC_LOAD, rd, 3'b010, `RVC_REG_SP,
				{4'b0, cinstr_i[3:2], cinstr_i[12], cinstr_i[6:4], 2'b00});
			// ldsp, offset scaled by 8
			3'b011: instr_o = pack_i(OPC_LOAD, rd, 3'b011, `RVC_REG_SP,
				{3'b0, cinstr_i[4:2], cinstr_i[12], cinstr_i[6:5], 3'b000});
			3'b100: begin
				case ({|rd, |rs2})
					2'b00: begin
						// ebreak; the same fields with bit 12 clear are reserved
						instr_o = pack_i(OPC_SYSTEM, `RVC_REG_ZERO, 3'b000,
							`RVC_REG_ZERO, 12'd1);
						illegal_o = ~cinstr_i[12];
					end
					// jr, jalr
					2'b10: instr_o = pack_i(OPC_JALR, link_rd, 3'b000, rd, 12'd0);
					// mv, add
					2'b11: instr_o = pack_r(OPC_OP, rd, 3'b000, add_rs1, rs2, 7'b0000000);
					// x0 destination with a source register
					default: illegal_o = 1'b1;
				endcase
			end
			// swsp
			3'b110: instr_o = pack_s(OPC_STORE, 3'b010, `RVC_REG_SP, rs2,
				{4'b0, cinstr_i[8:7], cinstr_i[12:9], 2'b00});
			// sdsp
			3'b111: instr_o = pack_s(OPC_STORE, 3'b011, `RVC_REG_SP, rs2,
				{3'b0, cinstr_i[9:7], cinstr_i[12:10], 3'b000});
			// fldsp, fsdsp
			default: illegal_o = 1'b1;
		endcase
	end

endmodule

`default_nettype wire

//--- verilog/rvc_expander.sv
// rv64c expander top: three quadrant decoders and the pass-through select
// one output register stage for the expanded word and its flags
`default_nettype none

`include "rvc_config.svh"

module rvc_expander import rvc_pkg::*; (
	input logic clk_i,
	input logic rst_n_i,
	input logic valid_i,
	input instr_t instr_i,
	output logic valid_o,
	output instr_t instr_o,
	output logic compressed_o,
	output logic illegal_o
);

	cinstr_t half;
	instr_t q0_instr;
	instr_t q1_instr;
	instr_t q2_instr;
	logic q0_illegal;
	logic q1_illegal;
	logic q2_illegal;
	instr_t exp_instr;
	logic exp_illegal;
	logic exp_compressed;

	// compressed form sits in the low half of the fetch word
	assign half = instr_i[`RVC_CLEN-1:0];

	rvc_quadrant0_dec u_q0 (
		.cinstr_i(half),
		.instr_o(q0_instr),
		.illegal_o(q0_illegal)
	);

	rvc_quadrant1_dec u_q1 (
		.cinstr_i(half),
		.instr_o(q1_instr),
		.illegal_o(q1_illegal)
	);

	rvc_quadrant2_dec u_q2 (
		.cinstr_i(half),
		.instr_o(q2_instr),
		.illegal_o(q2_illegal)
	);

	assign exp_compressed = instr_i[1:0] != `RVC_QUAD_FULL;

	// quadrant select on the low two bits
	always_comb begin
		case (instr_i[1:0])
			2'b00: {exp_instr, exp_illegal} = {q0_instr, q0_illegal};
			2'b01: {exp_instr, exp_illegal} = {q1_instr, q1_illegal};
			2'b10: {exp_instr, exp_illegal} = {q2_instr, q2_illegal};
			// full-width word goes through untouched
			default: {exp_instr, exp_illegal} = {instr_i, 1'b0};
		endcase
	end

	// outputs hold when no word is strobed in
	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			valid_o <= 1'b0;
			instr_o <= '0;
			compressed_o <= 1'b0;
			illegal_o <= 1'b0;
		end else begin
			valid_o <= valid_i;
			if (valid_i) begin
				instr_o <= exp_instr;
				compressed_o <= exp_compressed;
				illegal_o <= exp_illegal;
			end
		end
	end

endmodule

`default_nettype wire

//--- tb/rvc_expander_asserts.sv
// concurrent port checks for the expander, bound into rvc_expander
// reset, strobe timing, pass-through and compressed output form
`default_nettype none

module rvc_expander_asserts import rvc_pkg::*; (
	input logic clk_i,
	input logic rst_n_i,
	input logic valid_i,
	input instr_t instr_i,
	input logic valid_o,
	input instr_t instr_o,
	input logic compressed_o,
	input logic illegal_o
);
	timeunit 1ns;
	timeprecision 1ps;

	// one counter per property, summed for the testbench
	int fail_reset = 0;
	int fail_strobe = 0;
	int fail_pass = 0;
	int fail_form = 0;
	int fail_count;

	assign fail_count = fail_reset + fail_strobe + fail_pass + fail_form;

	// no output strobe while reset is held
	reset_quiet: assert property (@(posedge clk_i) !rst_n_i |=> !valid_o)
		else begin
			fail_reset++;
			$error("valid_o high after a reset cycle");
		end

	// valid_o follows valid_i by exactly one edge
	strobe_delay: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		1'b1 |=> valid_o == $past(valid_i))
		else begin
			fail_strobe++;
			$error("valid_o does not follow valid_i by one cycle");
		end

	// 32-bit words leave untouched and unflagged
	full_pass: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		valid_i && instr_i[1:0] == 2'b11 |=>
		instr_o == $past(instr_i) && !compressed_o && !illegal_o)
		else begin
			fail_pass++;
			$error("uncompressed word changed or flagged");
		end

	// legal expansions always end in 11
	comp_form: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		valid_i && instr_i[1:0] != 2'b11 |=>
		compressed_o && (illegal_o || instr_o[1:0] == 2'b11))
		else begin
			fail_form++;
			$error("compressed word gave a bad output form");
		end

endmodule

`default_nettype wire

//--- tb/rvc_expander_tb.sv
// testbench for the rv64c expander
// golden vectors, illegal encodings, random pass-through, back-to-back flow
`default_nettype none

module rvc_expander_tb import rvc_pkg::*; ();
	timeunit 1ns;
	timeprecision 1ps;

	localparam int TIMEOUT = 20;
	localparam int NGOLD = 32;
	localparam int NILL = 7;

	// {compressed half, expected expansion}
	localparam logic [47:0] GOLDEN [NGOLD] = '{
		// addi4spn, lw, ld, sw, sd
		48'h0800_01010413, 48'h4144_00452483, 48'h6504_00853483,
		48'hC144_00952223, 48'hE504_00953423,
		// addi, addiw, li, addi16sp, lui, srli, srai, andi
		48'h157D_FFF50513, 48'h2505_0015051B, 48'h4595_00500593,
		48'h6105_02010113, 48'h6605_00001637, 48'h8005_00145413,
		48'h8405_40145413, 48'h987D_FFF47413,
		// sub, xor, or, and, subw, addw
		48'h8C05_40940433, 48'h8C25_00944433, 48'h8C45_00946433,
		48'h8C65_00947433, 48'h9C05_4094043B, 48'h9C25_0094043B,
		// j, beqz, bnez
		48'hBFFD_FFFFF06F, 48'hC401_00040463, 48'hFC7D_FE041FE3,
		// slli, lwsp, ldsp, jr, mv, ebreak, jalr, add, swsp, sdsp
		48'h050E_00351513, 48'h4512_00412503, 48'h6522_00813503,
		48'h8082_00008067, 48'h852E_00B00533, 48'h9002_00100073,
		48'h9502_000500E7, 48'h952E_00B50533, 48'hC22A_00A12223,
		48'hE42A_00A13423
	};

	// zero word, mul slot, zext.b, not, fld, fsd, x0 mv
	localparam logic [15:0] ILLEGAL [NILL] = '{
		16'h0000, 16'h9C41, 16'h9C61, 16'h9C75, 16'h2000, 16'hA000, 16'h8006
	};

	logic clk_i;
	logic rst_n_i;
	logic valid_i;
	instr_t instr_i;
	logic valid_o;
	instr_t instr_o;
	logic compressed_o;
	logic illegal_o;

	int seed = 66784;
	int tests = 0;
	int errors = 0;

	always #10 clk_i = ~clk_i;

	rvc_expander u_dut (
		.clk_i(clk_i),
		.rst_n_i(rst_n_i),
		.valid_i(valid_i),
		.instr_i(instr_i),
		.valid_o(valid_o),
		.instr_o(instr_o),
		.compressed_o(compressed_o),
		.illegal_o(illegal_o)
	);

	bind rvc_expander rvc_expander_asserts u_chk (
		.clk_i(clk_i),
		.rst_n_i(rst_n_i),
		.valid_i(valid_i),
		.instr_i(instr_i),
		.valid_o(valid_o),
		.instr_o(instr_o),
		.compressed_o(compressed_o),
		.illegal_o(illegal_o)
	);

	// one-cycle strobe
	task automatic apply_word(input instr_t w);
		@(posedge clk_i);
		valid_i <= 1'b1;
		instr_i <= w;
		@(posedge clk_i);
		valid_i <= 1'b0;
	endtask

	// sampled on the falling edge, away from the register update
	task automatic wait_valid(output bit seen);
		int n;
		seen = 1'b0;
		for (n = 0; n < TIMEOUT && !seen; n++) begin
			@(negedge clk_i);
			seen = valid_o;
		end
	endtask

	task automatic expand_and_check(input string name, input instr_t w,
			input instr_t exp_instr, input logic exp_illegal, input bit check_instr);
		bit seen;
		bit ok;
		ok = 1'b1;
		apply_word(w);
		wait_valid(seen);
		if (!seen) begin
			$display("test %s timed out waiting for valid_o", name);
			ok = 1'b0;
		end else begin
			if (check_instr && instr_o !== exp_instr) begin
				$display("ERR %s expected %h actual %h", name, exp_instr, instr_o);
				ok = 1'b0;
			end
			if (illegal_o !== exp_illegal) begin
				$display("ERR %s illegal expected %b actual %b", name, exp_illegal, illegal_o);
				ok = 1'b0;
			end
		end
		tests++;
		if (!ok)
			errors++;
		$display("test %s %s", name, ok ? "ok" : "failed");
	endtask

	initial begin
		instr_t w;
		logic [31:0] rnd;
		bit seen;
		bit ok;
		int k;
		int j;
		clk_i = 1'b0;
		rst_n_i = 1'b0;
		// strobe held through the first reset edge
		valid_i = 1'b1;
		instr_i = '0;
		@(posedge clk_i);
		valid_i <= 1'b0;
		repeat (2) @(posedge clk_i);
		rst_n_i <= 1'b1;

		// upper half is noise, the expander must ignore it
		for (k = 0; k < NGOLD; k++) begin
			rnd = $random(seed);
			expand_and_check($sformatf("golden %0d", k), {rnd[31:16], GOLDEN[k][47:32]},
				GOLDEN[k][31:0], 1'b0, 1'b1);
		end
		for (k = 0; k < NILL; k++) begin
			rnd = $random(seed);
			expand_and_check($sformatf("illegal %0d", k), {rnd[31:16], ILLEGAL[k]},
				'0, 1'b1, 1'b0);
		end
		// random full-width words
		for (k = 0; k < 32; k++) begin
			rnd = $random(seed);
			w = {rnd[31:2], 2'b11};
			expand_and_check($sformatf("pass %0d", k), w, w, 1'b0, 1'b1);
		end

		// three words on consecutive edges, results on consecutive cycles
		ok = 1'b1;
		fork
			begin
				for (k = 0; k < 3; k++) begin
					@(posedge clk_i);
					valid_i <= 1'b1;
					instr_i <= {16'h0000, GOLDEN[k + 5][47:32]};
				end
				@(posedge clk_i);
				valid_i <= 1'b0;
			end
			begin
				wait_valid(seen);
				for (j = 0; j < 3; j++) begin
					if (j > 0)
						@(negedge clk_i);
					if (!seen || !valid_o) begin
						$display("back-to-back result %0d did not arrive", j);
						ok = 1'b0;
					end else if (instr_o !== GOLDEN[j + 5][31:0]) begin
						$display("ERR back-to-back %0d expected %h actual %h", j,
							GOLDEN[j + 5][31:0], instr_o);
						ok = 1'b0;
					end
				end
			end
		join
		tests++;
		if (!ok)
			errors++;
		$display("test back-to-back %s", ok ? "ok" : "failed");

		// let the last assertions settle
		repeat (2) @(negedge clk_i);
		$display("tests %0d, failed %0d, assertion failures %0d", tests, errors,
			u_dut.u_chk.fail_count);
		if (errors == 0 && u_dut.u_chk.fail_count == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- build.f
+incdir+verilog
verilog/rvc_pkg.sv
verilog/rvc_quadrant0_dec.sv
verilog/rvc_quadrant1_dec.sv
verilog/rvc_quadrant2_dec.sv
verilog/rvc_expander.sv
tb/rvc_expander_asserts.sv
tb/rvc_expander_tb.sv

//--- Makefile
# Verilator build and run for the RV64C expander testbench

VERILATOR ?= verilator
TOP ?= rvc_expander_tb
FILELIST ?= build.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert --timescale 1ns/1ps -j 0
RUN_ARGS ?= +verilator+error+limit+100

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the run passes only if the pass line shows up in the simulator output
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -q '^STATUS: PASS$$'

clean:
	rm -rf $(OBJ_DIR)
